// File: hw/shade_pkg.sv
package shade_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // number formats

    // signed Q16.16 coordinate or vector component
    typedef logic signed [31:0] fx_t;
    localparam int FRAC_BITS = 16;

    // 8-bit colour channel and Q0.8 light intensity
    typedef logic [7:0] color_t;
    typedef logic [7:0] intensity_t;
    localparam int COLOR_MAX = 255;

    // integer part only, fraction bits left at zero
    function automatic fx_t int_to_fx(input int value);
        return fx_t'(value) <<< FRAC_BITS;
    endfunction

    // upper clamp of the lambert term
    localparam fx_t LAMBERT_ONE = int_to_fx(1);

    ////////////////////////////////////////////////////////////////////////////
    // scene constants

    localparam fx_t EYE_X = int_to_fx(1800);
    localparam fx_t EYE_Y = int_to_fx(1800);
    localparam fx_t EYE_Z = int_to_fx(-300);

    localparam int MAX_LIGHTS = 4;

    localparam fx_t LIGHT_POS_X [MAX_LIGHTS] = '{
        int_to_fx(1400), int_to_fx(1800), int_to_fx(2200), int_to_fx(1800)
    };
    localparam fx_t LIGHT_POS_Y [MAX_LIGHTS] = '{
        int_to_fx(1800), int_to_fx(1800), int_to_fx(1800), int_to_fx(1400)
    };
    localparam fx_t LIGHT_POS_Z [MAX_LIGHTS] = '{
        int_to_fx(100), int_to_fx(100), int_to_fx(100), int_to_fx(100)
    };

    // intensities in 256ths of full brightness
    localparam intensity_t LIGHT_INT_R [MAX_LIGHTS] = '{8'd64, 8'd192, 8'd64, 8'd32};
    localparam intensity_t LIGHT_INT_G [MAX_LIGHTS] = '{8'd128, 8'd128, 8'd128, 8'd32};
    localparam intensity_t LIGHT_INT_B [MAX_LIGHTS] = '{8'd64, 8'd192, 8'd64, 8'd32};

endpackage

// File: hw/surface_if.sv
`timescale 1ns/1ps

interface surface_if;
    import shade_pkg::*;

    // hit point on the block surface
    fx_t hit_x, hit_y, hit_z;
    // unnormalized normal, hit point minus block centre
    fx_t norm_x, norm_y, norm_z;
    color_t mat_r, mat_g, mat_b;
    logic valid;

    modport source (
        output hit_x, hit_y, hit_z,
        output norm_x, norm_y, norm_z,
        output mat_r, mat_g, mat_b,
        output valid
    );

    modport sink (
        input hit_x, hit_y, hit_z,
        input norm_x, norm_y, norm_z,
        input mat_r, mat_g, mat_b,
        input valid
    );

endinterface

// File: hw/light_term_if.sv
`timescale 1ns/1ps

interface light_term_if;
    import shade_pkg::*;

    // one light's share of the pixel colour
    color_t term_r, term_g, term_b;
    logic valid;

    modport source (
        output term_r, term_g, term_b,
        output valid
    );

    modport sink (
        input term_r, term_g, term_b,
        input valid
    );

endinterface

// File: hw/hit_point_stage.sv
`timescale 1ns/1ps

module hit_point_stage (
    input  logic             clk_in,
    input  logic             rst_in,
    input  logic             valid_in,
    input  shade_pkg::fx_t   ray_x,
    input  shade_pkg::fx_t   ray_y,
    input  shade_pkg::fx_t   ray_z,
    input  shade_pkg::fx_t   t_in,
    input  shade_pkg::fx_t   block_pos_x,
    input  shade_pkg::fx_t   block_pos_y,
    input  shade_pkg::fx_t   block_pos_z,
    input  shade_pkg::color_t mat_r,
    input  shade_pkg::color_t mat_g,
    input  shade_pkg::color_t mat_b,
    surface_if.source        surf
);
    import shade_pkg::*;

    // full-width ray times t, Q32.32
    logic signed [63:0] scaled_x, scaled_y, scaled_z;

    // stage 1 registers
    fx_t    hit_x_q, hit_y_q, hit_z_q;
    fx_t    blk_x_q, blk_y_q, blk_z_q;
    color_t mat_r_q, mat_g_q, mat_b_q;
    logic   s1_valid;

    always_comb begin
        scaled_x = ray_x * t_in;
        scaled_y = ray_y * t_in;
        scaled_z = ray_z * t_in;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage 1: hit point = eye + ray * t

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= valid_in;
        end
    end

    always_ff @(posedge clk_in) begin
        hit_x_q <= EYE_X + fx_t'(scaled_x >>> FRAC_BITS);
        hit_y_q <= EYE_Y + fx_t'(scaled_y >>> FRAC_BITS);
        hit_z_q <= EYE_Z + fx_t'(scaled_z >>> FRAC_BITS);
        // centre and material follow their sample
        blk_x_q <= block_pos_x;
        blk_y_q <= block_pos_y;
        blk_z_q <= block_pos_z;
        mat_r_q <= mat_r;
        mat_g_q <= mat_g;
        mat_b_q <= mat_b;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage 2: normal = hit point - block centre

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            surf.valid <= 1'b0;
        end else begin
            surf.valid <= s1_valid;
        end
    end

    always_ff @(posedge clk_in) begin
        surf.hit_x  <= hit_x_q;
        surf.hit_y  <= hit_y_q;
        surf.hit_z  <= hit_z_q;
        surf.norm_x <= hit_x_q - blk_x_q;
        surf.norm_y <= hit_y_q - blk_y_q;
        surf.norm_z <= hit_z_q - blk_z_q;
        surf.mat_r  <= mat_r_q;
        surf.mat_g  <= mat_g_q;
        surf.mat_b  <= mat_b_q;
    end

endmodule

// File: hw/light_lane.sv
`timescale 1ns/1ps

module light_lane #(
    parameter int LIGHT_INDEX = 0
) (
    input  logic        clk_in,
    input  logic        rst_in,
    surface_if.sink     surf,
    light_term_if.source term
);
    import shade_pkg::*;

    // lambert term runs from 0 to exactly 1.0
    localparam int LAMBERT_W = FRAC_BITS + 1;

    // stage 1 registers
    fx_t    s1_dist_x, s1_dist_y, s1_dist_z;
    fx_t    s1_norm_x, s1_norm_y, s1_norm_z;
    color_t s1_mat_r, s1_mat_g, s1_mat_b;
    logic   s1_valid;

    // stage 2 registers and their inputs
    logic signed [63:0]   dot_sum;
    logic signed [63:0]   dot_fx;
    logic [LAMBERT_W-1:0] lambert_next;
    logic [LAMBERT_W-1:0] s2_lambert;
    color_t               s2_mat_r, s2_mat_g, s2_mat_b;
    logic                 s2_valid;

    // material * intensity * lambert, before the final shift
    logic [LAMBERT_W+15:0] shade_r, shade_g, shade_b;

    ////////////////////////////////////////////////////////////////////////////
    // stage 1: vector from hit point to this light

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= surf.valid;
        end
    end

    always_ff @(posedge clk_in) begin
        s1_dist_x <= LIGHT_POS_X[LIGHT_INDEX] - surf.hit_x;
        s1_dist_y <= LIGHT_POS_Y[LIGHT_INDEX] - surf.hit_y;
        s1_dist_z <= LIGHT_POS_Z[LIGHT_INDEX] - surf.hit_z;
        s1_norm_x <= surf.norm_x;
        s1_norm_y <= surf.norm_y;
        s1_norm_z <= surf.norm_z;
        s1_mat_r  <= surf.mat_r;
        s1_mat_g  <= surf.mat_g;
        s1_mat_b  <= surf.mat_b;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage 2: clamped lambert term

    always_comb begin
        dot_sum = s1_dist_x * s1_norm_x + s1_dist_y * s1_norm_y + s1_dist_z * s1_norm_z;
        dot_fx  = dot_sum >>> FRAC_BITS;
        // back-facing gives zero, no normalization so cap at one
        if (dot_fx < 0) begin
            lambert_next = '0;
        end else if (dot_fx > LAMBERT_ONE) begin
            lambert_next = LAMBERT_W'(LAMBERT_ONE);
        end else begin
            lambert_next = LAMBERT_W'(dot_fx);
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk_in) begin
        s2_lambert <= lambert_next;
        s2_mat_r   <= s1_mat_r;
        s2_mat_g   <= s1_mat_g;
        s2_mat_b   <= s1_mat_b;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage 3: weighted colour

    always_comb begin
        shade_r = s2_mat_r * LIGHT_INT_R[LIGHT_INDEX] * s2_lambert;
        shade_g = s2_mat_g * LIGHT_INT_G[LIGHT_INDEX] * s2_lambert;
        shade_b = s2_mat_b * LIGHT_INT_B[LIGHT_INDEX] * s2_lambert;
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            term.valid <= 1'b0;
        end else begin
            term.valid <= s2_valid;
        end
    end

    // drop the Q0.8 intensity and Q16 lambert fractions
    always_ff @(posedge clk_in) begin
        term.term_r <= color_t'(shade_r >> (8 + FRAC_BITS));
        term.term_g <= color_t'(shade_g >> (8 + FRAC_BITS));
        term.term_b <= color_t'(shade_b >> (8 + FRAC_BITS));
    end

endmodule

// File: hw/color_accumulate.sv
`timescale 1ns/1ps

module color_accumulate #(
    parameter int NUM_LIGHTS = 3
) (
    input  logic              clk_in,
    input  logic              rst_in,
    light_term_if.sink        terms [NUM_LIGHTS],
    output shade_pkg::color_t r_out,
    output shade_pkg::color_t g_out,
    output shade_pkg::color_t b_out,
    output logic              rgb_valid
);
    import shade_pkg::*;

    // room for every light at full channel value
    localparam int SUM_W = $bits(color_t) + $clog2(MAX_LIGHTS);

    color_t lane_r [NUM_LIGHTS];
    color_t lane_g [NUM_LIGHTS];
    color_t lane_b [NUM_LIGHTS];
    logic   lane_valid;

    logic [SUM_W-1:0] sum_r, sum_g, sum_b;

    // flatten the interface array
    for (genvar i = 0; i < NUM_LIGHTS; i++) begin : g_lane
        assign lane_r[i] = terms[i].term_r;
        assign lane_g[i] = terms[i].term_g;
        assign lane_b[i] = terms[i].term_b;
    end

    // lanes run in lockstep
    assign lane_valid = terms[0].valid;

    always_comb begin
        sum_r = '0;
        sum_g = '0;
        sum_b = '0;
        for (int i = 0; i < NUM_LIGHTS; i++) begin
            sum_r = sum_r + SUM_W'(lane_r[i]);
            sum_g = sum_g + SUM_W'(lane_g[i]);
            sum_b = sum_b + SUM_W'(lane_b[i]);
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            rgb_valid <= 1'b0;
            r_out     <= '0;
            g_out     <= '0;
            b_out     <= '0;
        end else begin
            rgb_valid <= lane_valid;
            if (lane_valid) begin
                // saturate instead of wrapping
                r_out <= (sum_r > COLOR_MAX) ? color_t'(COLOR_MAX) : color_t'(sum_r);
                g_out <= (sum_g > COLOR_MAX) ? color_t'(COLOR_MAX) : color_t'(sum_g);
                b_out <= (sum_b > COLOR_MAX) ? color_t'(COLOR_MAX) : color_t'(sum_b);
            end
        end
    end

endmodule

// File: hw/pixel_shader.sv
`timescale 1ns/1ps

module pixel_shader #(
    parameter int NUM_LIGHTS = 3
) (
    input  logic              clk_in,
    input  logic              rst_in,

    // one hit sample per cycle while valid_in is high
    input  logic              valid_in,
    input  shade_pkg::fx_t    ray_x,
    input  shade_pkg::fx_t    ray_y,
    input  shade_pkg::fx_t    ray_z,
    input  shade_pkg::fx_t    t_in,
    input  shade_pkg::fx_t    block_pos_x,
    input  shade_pkg::fx_t    block_pos_y,
    input  shade_pkg::fx_t    block_pos_z,
    input  shade_pkg::color_t mat_r,
    input  shade_pkg::color_t mat_g,
    input  shade_pkg::color_t mat_b,

    // shaded colour, six cycles after the sample
    output shade_pkg::color_t r_out,
    output shade_pkg::color_t g_out,
    output shade_pkg::color_t b_out,
    output logic              rgb_valid
);

    surface_if    surf ();
    light_term_if lane_term [NUM_LIGHTS] ();

    ////////////////////////////////////////////////////////////////////////////
    // hit point and normal

    hit_point_stage u_hit_point (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .valid_in    (valid_in),
        .ray_x       (ray_x),
        .ray_y       (ray_y),
        .ray_z       (ray_z),
        .t_in        (t_in),
        .block_pos_x (block_pos_x),
        .block_pos_y (block_pos_y),
        .block_pos_z (block_pos_z),
        .mat_r       (mat_r),
        .mat_g       (mat_g),
        .mat_b       (mat_b),
        .surf        (surf.source)
    );

    ////////////////////////////////////////////////////////////////////////////
    // one lane per light, all fed from the same surface sample

    for (genvar i = 0; i < NUM_LIGHTS; i++) begin : g_light
        light_lane #(
            .LIGHT_INDEX (i)
        ) u_lane (
            .clk_in (clk_in),
            .rst_in (rst_in),
            .surf   (surf.sink),
            .term   (lane_term[i].source)
        );
    end

    color_accumulate #(
        .NUM_LIGHTS (NUM_LIGHTS)
    ) u_accumulate (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .terms     (lane_term),
        .r_out     (r_out),
        .g_out     (g_out),
        .b_out     (b_out),
        .rgb_valid (rgb_valid)
    );

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD_NS = 10.0
) (
    output logic clk
);

    // free-running, first rising edge after half a period
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0);
            clk = ~clk;
        end
    end

endmodule

// File: testbench/tb_pixel_shader.sv
`timescale 1ns/1ps

module tb_pixel_shader;
    import shade_pkg::*;

    localparam int N_LIGHTS     = 3;
    localparam int RESET_CYCLES = 10;
    localparam int LATENCY      = 6;
    localparam int N_RANDOM     = 300;
    localparam int N_CORNER     = 8;
    localparam int N_BURST      = 50;
    // six tests, each allowed (samples + latency) * 2 cycles
    localparam int WATCHDOG_CYCLES = RESET_CYCLES
        + 2 * (1 + N_RANDOM + 2 * N_CORNER + N_BURST + 6 * LATENCY);
    localparam fx_t FX_ONE = 32'sh0001_0000;

    logic   clk_in, rst_in, valid_in, rgb_valid;
    fx_t    ray_x, ray_y, ray_z, t_in, block_pos_x, block_pos_y, block_pos_z;
    color_t mat_r, mat_g, mat_b, r_out, g_out, b_out;

    logic [15:0] lfsr_state = 16'd54;
    logic [23:0] expected_q [$];
    logic [23:0] expected_now;
    string       test_name;
    int test_errors, total_errors, tests_run, tests_failed;
    int test_in, test_out, neg_cycle, first_out, last_out;

    tb_clock #(.PERIOD_NS(10.0)) u_clock (.clk(clk_in));

    pixel_shader #(
        .NUM_LIGHTS (N_LIGHTS)
    ) u_dut (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .valid_in    (valid_in),
        .ray_x       (ray_x),
        .ray_y       (ray_y),
        .ray_z       (ray_z),
        .t_in        (t_in),
        .block_pos_x (block_pos_x),
        .block_pos_y (block_pos_y),
        .block_pos_z (block_pos_z),
        .mat_r       (mat_r),
        .mat_g       (mat_g),
        .mat_b       (mat_b),
        .r_out       (r_out),
        .g_out       (g_out),
        .b_out       (b_out),
        .rgb_valid   (rgb_valid)
    );

    ////////////////////////////////////////////////////////////////////////////
    // random source and reference model

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    function automatic fx_t take_signed(input int width);
        logic [31:0] raw;
        raw = take_bits(width);
        return fx_t'(raw << (32 - width)) >>> (32 - width);
    endfunction

    function automatic fx_t hit_axis(input fx_t eye, input fx_t ray, input fx_t t);
        longint prod;
        prod = longint'(ray) * longint'(t);
        return eye + fx_t'(prod >>> FRAC_BITS);
    endfunction

    function automatic color_t saturate(input int value);
        return (value > 255) ? 8'd255 : color_t'(value);
    endfunction

    function automatic logic [23:0] expected_rgb(input fx_t rx, ry, rz, t, bx, by, bz,
                                                 input color_t mr, mg, mb);
        fx_t    hx, hy, hz, nx, ny, nz, dx, dy, dz;
        longint dot, lam, one;
        int     sum_r, sum_g, sum_b;
        hx = hit_axis(EYE_X, rx, t);
        hy = hit_axis(EYE_Y, ry, t);
        hz = hit_axis(EYE_Z, rz, t);
        nx = hx - bx;
        ny = hy - by;
        nz = hz - bz;
        one = longint'(1) <<< FRAC_BITS;
        sum_r = 0;
        sum_g = 0;
        sum_b = 0;
        for (int l = 0; l < N_LIGHTS; l++) begin
            dx = LIGHT_POS_X[l] - hx;
            dy = LIGHT_POS_Y[l] - hy;
            dz = LIGHT_POS_Z[l] - hz;
            dot = longint'(dx) * nx + longint'(dy) * ny + longint'(dz) * nz;
            lam = dot >>> FRAC_BITS;
            if (lam < 0) begin
                lam = 0;
            end else if (lam > one) begin
                lam = one;
            end
            sum_r += int'((longint'(mr) * LIGHT_INT_R[l] * lam) >> (8 + FRAC_BITS));
            sum_g += int'((longint'(mg) * LIGHT_INT_G[l] * lam) >> (8 + FRAC_BITS));
            sum_b += int'((longint'(mb) * LIGHT_INT_B[l] * lam) >> (8 + FRAC_BITS));
        end
        return {saturate(sum_r), saturate(sum_g), saturate(sum_b)};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // stimulus

    task automatic note_error();
        test_errors++;
        total_errors++;
    endtask

    task automatic send_sample(input fx_t rx, ry, rz, t, bx, by, bz, input color_t mr, mg, mb);
        @(posedge clk_in);
        valid_in    <= 1'b1;
        ray_x       <= rx;
        ray_y       <= ry;
        ray_z       <= rz;
        t_in        <= t;
        block_pos_x <= bx;
        block_pos_y <= by;
        block_pos_z <= bz;
        mat_r       <= mr;
        mat_g       <= mg;
        mat_b       <= mb;
        expected_q.push_back(expected_rgb(rx, ry, rz, t, bx, by, bz, mr, mg, mb));
        test_in++;
    endtask

    task automatic idle_cycle();
        @(posedge clk_in);
        valid_in <= 1'b0;
    endtask

    task automatic send_random();
        fx_t    rx, ry, rz, t, nx, ny, nz;
        color_t mr, mg, mb;
        // |ray| < 2.0 and t < 1024 keep hits within 4096 of the origin
        rx = take_signed(18);
        ry = take_signed(18);
        rz = take_signed(18);
        t  = fx_t'(take_bits(26));
        // normal from a tiny fraction up to several units
        nx = take_signed(6 + 4 * take_bits(2));
        ny = take_signed(6 + 4 * take_bits(2));
        nz = take_signed(6 + 4 * take_bits(2));
        mr = color_t'(take_bits(8));
        mg = color_t'(take_bits(8));
        mb = color_t'(take_bits(8));
        send_sample(rx, ry, rz, t, hit_axis(EYE_X, rx, t) - nx, hit_axis(EYE_Y, ry, t) - ny,
                    hit_axis(EYE_Z, rz, t) - nz, mr, mg, mb);
    endtask

    // ray along +z, so the hit sits below every light
    task automatic send_facing(input bit away);
        fx_t    t, k, hz, bz;
        color_t mr, mg, mb;
        t  = fx_t'(100 + take_bits(7)) <<< FRAC_BITS;
        k  = fx_t'(1 + take_bits(3)) <<< FRAC_BITS;
        hz = hit_axis(EYE_Z, FX_ONE, t);
        bz = away ? hz + k : hz - k;
        mr = away ? color_t'(take_bits(8)) : 8'd255;
        mg = away ? color_t'(take_bits(8)) : 8'd255;
        mb = away ? color_t'(take_bits(8)) : 8'd255;
        assert (expected_rgb('0, '0, FX_ONE, t, EYE_X, EYE_Y, bz, mr, mg, mb)
                == (away ? 24'h000000 : 24'hffffff)) else begin
            $display("Stimulus in %s does not give the intended corner colour", test_name);
            note_error();
        end
        send_sample('0, '0, FX_ONE, t, EYE_X, EYE_Y, bz, mr, mg, mb);
    endtask

    task automatic check_quiet();
        assert (rgb_valid === 1'b0 && {r_out, g_out, b_out} === 24'h000000) else begin
            $display("Mismatch in %s: expected valid 0 rgb 000000 actual valid %b rgb %06h",
                     test_name, rgb_valid, {r_out, g_out, b_out});
            note_error();
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
        test_in     = 0;
        test_out    = 0;
    endtask

    // wait for every outstanding result, then compare the counts
    task automatic drain();
        idle_cycle();
        while (expected_q.size() != 0) begin
            @(negedge clk_in);
        end
        @(negedge clk_in);
        assert (test_out == test_in) else begin
            $display("Mismatch in %s: expected %0d results actual %0d",
                     test_name, test_in, test_out);
            note_error();
        end
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("test %-14s ok, %0d in, %0d out", test_name, test_in, test_out);
        end else begin
            tests_failed++;
            $display("test %-14s failed with %0d errors", test_name, test_errors);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // scoreboard, sampled on the falling edge

    always @(negedge clk_in) begin
        neg_cycle++;
        if (!rst_in && rgb_valid) begin
            assert (expected_q.size() != 0) else begin
                $display("Result in %s arrived with no sample outstanding", test_name);
                note_error();
            end
            if (expected_q.size() != 0) begin
                expected_now = expected_q.pop_front();
                assert ({r_out, g_out, b_out} === expected_now) else begin
                    $display("Mismatch in %s: expected %06h actual %06h",
                             test_name, expected_now, {r_out, g_out, b_out});
                    note_error();
                end
            end
            if (test_out == 0) begin
                first_out = neg_cycle;
            end
            last_out = neg_cycle;
            test_out++;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_in);
        $display("Watchdog expired after %0d cycles in %s", WATCHDOG_CYCLES, test_name);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        int cycles;
        rst_in       = 1'b1;
        valid_in     = 1'b0;
        {ray_x, ray_y, ray_z, t_in} = '0;
        {block_pos_x, block_pos_y, block_pos_z} = '0;
        {mat_r, mat_g, mat_b} = '0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        neg_cycle    = 0;

        begin_test("reset_quiet");
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk_in);
            if (i == RESET_CYCLES - 1) begin
                rst_in <= 1'b0;
            end
            @(negedge clk_in);
            check_quiet();
        end
        repeat (4) begin
            @(negedge clk_in);
            check_quiet();
        end
        end_test();

        begin_test("latency");
        send_random();
        cycles = 0;
        @(negedge clk_in);
        while (!rgb_valid && cycles < 4 * LATENCY) begin
            @(posedge clk_in);
            valid_in <= 1'b0;
            @(negedge clk_in);
            cycles++;
        end
        assert (cycles == LATENCY) else begin
            $display("Mismatch in %s: expected %0d cycles actual %0d",
                     test_name, LATENCY, cycles);
            note_error();
        end
        @(negedge clk_in);
        assert (!rgb_valid) else begin
            $display("rgb_valid stayed high for more than one cycle in %s", test_name);
            note_error();
        end
        drain();
        end_test();

        begin_test("random_stream");
        for (int i = 0; i < N_RANDOM; i++) begin
            send_random();
            if (take_bits(1) == 1) begin
                idle_cycle();
            end
        end
        drain();
        end_test();

        begin_test("back_facing");
        repeat (N_CORNER) send_facing(1'b1);
        drain();
        end_test();

        begin_test("saturation");
        repeat (N_CORNER) send_facing(1'b0);
        drain();
        end_test();

        begin_test("burst");
        repeat (N_BURST) send_random();
        drain();
        assert (last_out - first_out == N_BURST - 1) else begin
            $display("Burst results in %s did not leave on consecutive cycles", test_name);
            note_error();
        end
        end_test();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: build.f
hw/shade_pkg.sv
hw/surface_if.sv
hw/light_term_if.sv
hw/hit_point_stage.sv
hw/light_lane.sv
hw/color_accumulate.sv
hw/pixel_shader.sv
testbench/tb_clock.sv
testbench/tb_pixel_shader.sv

// File: run.sh
#!/bin/sh
# build the pixel shader testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_pixel_shader \
    -f build.f -Mdir obj_dir -o sim_pixel_shader > build.log 2>&1 &&
./obj_dir/sim_pixel_shader > sim.log 2>&1 ||
{ cat build.log; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Testbench failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
